/* Makefile */
SIM      := verilator
TOP      := uartBridgeTb
FILELIST := compile.f
FLAGS    := --binary --timing --assert --timescale 1ns/100ps -Wno-fatal --top-module $(TOP)
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
RUNFLAGS := +verilator+error+limit+1000
LOG      := sim.log
FAIL_MSG := === FAIL ===
SOURCES  := $(wildcard rtl/*.sv test/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(SIM) $(FLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@$(BIN) $(RUNFLAGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* compile.f */
rtl/uartPkg.sv
rtl/memPort.sv
rtl/uartRx.sv
rtl/uartTx.sv
rtl/ringBuffer.sv
rtl/arbitratedRam.sv
rtl/uartBridge.sv
test/uartBridge_chk.sv
test/uartBridgeTb.sv

/* rtl/arbitratedRam.sv */
`default_nettype none

module arbitratedRam #(
  parameter int queueDepthLog2 = 2
) (
  input  wire    clk,
  input  wire    reset,
  memPort.server portA,
  memPort.server portB
);
  import uartPkg::*;

  localparam int addrWidth = queueDepthLog2 + 1;

  byteT                 ram [2**addrWidth];
  logic                 lastB;   // Port B won the previous grant
  logic                 grantA;
  logic                 grantB;
  logic [addrWidth-1:0] addr;
  memOpT                op;
  byteT                 wrData;
  byteT                 rdReg;

  // Round robin only matters when both ask in the same cycle
  assign grantA = portA.reqValid && (!portB.reqValid || lastB);
  assign grantB = portB.reqValid && !grantA;

  assign portA.reqReady = grantA;
  assign portB.reqReady = grantB;

  assign addr   = grantA ? portA.addr : portB.addr;
  assign op     = grantA ? portA.op : portB.op;
  assign wrData = grantA ? portA.wrData : portB.wrData;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      lastB         <= 1'b0;
      portA.rdValid <= 1'b0;
      portB.rdValid <= 1'b0;
    end
    else
    begin
      if (grantA)
        lastB <= 1'b0;
      else if (grantB)
        lastB <= 1'b1;
      portA.rdValid <= grantA && (portA.op == memRead);
      portB.rdValid <= grantB && (portB.op == memRead);
    end
  end

  // Single port, one access per cycle
  always_ff @(posedge clk)
  begin
    if (grantA || grantB)
    begin
      if (op == memWrite)
        ram[addr] <= wrData;
      else
        rdReg <= ram[addr];
    end
  end

  // Only the port with rdValid looks at the data
  assign portA.rdData = rdReg;
  assign portB.rdData = rdReg;

endmodule

`default_nettype wire

/* rtl/memPort.sv */
`default_nettype none

interface memPort #(
  parameter int queueDepthLog2 = 2
);
  import uartPkg::*;

  // Top address bit selects the queue region
  localparam int addrWidth = queueDepthLog2 + 1;

  logic                 reqValid;
  memOpT                op;
  logic [addrWidth-1:0] addr;
  byteT                 wrData;
  logic                 reqReady;
  logic                 rdValid; // One cycle after a read transfers
  byteT                 rdData;

  modport client (
    output reqValid, op, addr, wrData,
    input  reqReady, rdValid, rdData
  );

  modport server (
    input  reqValid, op, addr, wrData,
    output reqReady, rdValid, rdData
  );

endinterface

`default_nettype wire

/* rtl/ringBuffer.sv */
`default_nettype none

module ringBuffer #(
  parameter int queueDepthLog2 = 2,
  parameter bit regionSel      = 1'b0
) (
  input  wire           clk,
  input  wire           reset,
  input  wire           inValid,
  input  uartPkg::byteT inData,
  output logic          inReady,
  output logic          outValid,
  output uartPkg::byteT outData,
  input  wire           outReady,
  output logic          dropped,
  memPort.client        mem
);
  import uartPkg::*;

  localparam int cntW = queueDepthLog2 + 1;
  localparam logic [cntW-1:0] depth = cntW'(2 ** queueDepthLog2);

  logic [queueDepthLog2-1:0] head;
  logic [queueDepthLog2-1:0] tail;
  logic [cntW-1:0]           count;   // Staged, stored and prefetched entries
  logic [cntW-1:0]           stored;
  logic                      active;
  logic                      stageValid;
  byteT                      stageData;
  logic                      readHeld;
  logic                      canPrefetch;
  logic                      selRead;
  logic                      accept;
  logic                      pop;
  logic                      writeDone;

  assign stored      = count - cntW'(stageValid);
  assign canPrefetch = (stored != '0) && !outValid && !mem.rdValid;
  // An unfinished read keeps the port, otherwise writes win
  assign selRead     = readHeld || (!stageValid && canPrefetch);

  assign inReady   = active && !stageValid && (count != depth);
  assign accept    = inValid && inReady;
  assign pop       = outValid && outReady;
  assign writeDone = stageValid && !selRead && mem.reqReady;

  assign mem.reqValid = selRead || stageValid;
  assign mem.op       = selRead ? memRead : memWrite;
  assign mem.addr     = selRead ? {regionSel, head} : {regionSel, tail};
  assign mem.wrData   = stageData;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      head       <= '0;
      tail       <= '0;
      count      <= '0;
      active     <= 1'b0;
      stageValid <= 1'b0;
      readHeld   <= 1'b0;
      outValid   <= 1'b0;
      dropped    <= 1'b0;
    end
    else
    begin
      active   <= 1'b1;
      readHeld <= selRead && !mem.reqReady;
      count    <= count + cntW'(accept) - cntW'(pop);
      if (inValid && !inReady)
        dropped <= 1'b1; // Held until reset
      if (accept)
        stageValid <= 1'b1;
      else if (writeDone)
        stageValid <= 1'b0;
      if (writeDone)
        tail <= tail + 1'b1;
      if (mem.rdValid)
        outValid <= 1'b1;
      else if (pop)
      begin
        outValid <= 1'b0;
        head     <= head + 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
      stageData <= inData;
    if (mem.rdValid)
      outData <= mem.rdData; // Head entry, stable until popped
  end

endmodule

`default_nettype wire

/* rtl/uartBridge.sv */
`default_nettype none

module uartBridge #(
  parameter int clksPerBit     = 16,
  parameter int queueDepthLog2 = 2
) (
  input  wire           clk,
  input  wire           reset,
  input  uartPkg::byteT txData,
  input  wire           txValid,
  output logic          txReady,
  output uartPkg::byteT rxData,
  output logic          rxValid,
  input  wire           rxReady,
  input  wire           serialIn,
  output logic          serialOut,
  output logic          rxOverrun,
  output logic          rxFrameError
);
  import uartPkg::*;

  logic txLinkValid;
  logic txLinkReady;
  byteT txLinkData;
  logic rxByteValid;
  byteT rxByte;

  memPort #(.queueDepthLog2(queueDepthLog2)) txMem ();
  memPort #(.queueDepthLog2(queueDepthLog2)) rxMem ();

  // Lower half of the RAM
  ringBuffer #(.queueDepthLog2(queueDepthLog2), .regionSel(1'b0)) txQueue (
    .clk      (clk),
    .reset    (reset),
    .inValid  (txValid),
    .inData   (txData),
    .inReady  (txReady),
    .outValid (txLinkValid),
    .outData  (txLinkData),
    .outReady (txLinkReady),
    .dropped  (),            // Host is back-pressured instead
    .mem      (txMem.client)
  );

  // Upper half of the RAM
  ringBuffer #(.queueDepthLog2(queueDepthLog2), .regionSel(1'b1)) rxQueue (
    .clk      (clk),
    .reset    (reset),
    .inValid  (rxByteValid),
    .inData   (rxByte),
    .inReady  (),            // Line cannot stall
    .outValid (rxValid),
    .outData  (rxData),
    .outReady (rxReady),
    .dropped  (rxOverrun),
    .mem      (rxMem.client)
  );

  arbitratedRam #(.queueDepthLog2(queueDepthLog2)) ram0 (
    .clk   (clk),
    .reset (reset),
    .portA (txMem.server),
    .portB (rxMem.server)
  );

  uartTx #(.clksPerBit(clksPerBit)) tx0 (
    .clk         (clk),
    .reset       (reset),
    .txByteValid (txLinkValid),
    .txByte      (txLinkData),
    .txByteReady (txLinkReady),
    .serialOut   (serialOut)
  );

  uartRx #(.clksPerBit(clksPerBit)) rx0 (
    .clk         (clk),
    .reset       (reset),
    .serialIn    (serialIn),
    .rxByteValid (rxByteValid),
    .rxByte      (rxByte),
    .frameError  (rxFrameError)
  );

endmodule

`default_nettype wire

/* rtl/uartPkg.sv */
`default_nettype none

package uartPkg;

  // 8N1 framing, data width of every byte path
  localparam int dataBits = 8;

  typedef logic [dataBits-1:0] byteT;

  // Opcode of a request on the shared RAM
  typedef enum logic
  {
    memRead  = 1'b0,
    memWrite = 1'b1
  } memOpT;

  typedef enum logic [1:0]
  {
    rxIdle  = 2'd0,
    rxStart = 2'd1, // Waiting for the middle of the start bit
    rxData  = 2'd2,
    rxStop  = 2'd3
  } rxStateT;

  typedef enum logic [1:0]
  {
    txIdle  = 2'd0,
    txStart = 2'd1,
    txData  = 2'd2,
    txStop  = 2'd3
  } txStateT;

endpackage

`default_nettype wire

/* rtl/uartRx.sv */
`default_nettype none

module uartRx #(
  parameter int clksPerBit = 16
) (
  input  wire          clk,
  input  wire          reset,
  input  wire          serialIn,
  output logic         rxByteValid,
  output uartPkg::byteT rxByte,
  output logic         frameError
);
  import uartPkg::*;

  localparam int cntW = $clog2(clksPerBit);
  localparam int bitW = $clog2(dataBits);
  localparam logic [cntW-1:0] lastCnt = cntW'(clksPerBit - 1);
  localparam logic [cntW-1:0] halfCnt = cntW'(clksPerBit / 2 - 1);
  localparam logic [bitW-1:0] lastBit = bitW'(dataBits - 1);

  rxStateT         state;
  logic            syncA;
  logic            syncB;
  logic [cntW-1:0] baudCnt;
  logic [bitW-1:0] bitIdx;
  byteT            shiftReg;
  logic            sampleData;

  // Two-flop synchronizer, idles high like the line
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      syncA <= 1'b1;
      syncB <= 1'b1;
    end
    else
    begin
      syncA <= serialIn;
      syncB <= syncA;
    end
  end

  assign sampleData = (state == rxData) && (baudCnt == lastCnt);

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      state       <= rxIdle;
      baudCnt     <= '0;
      bitIdx      <= '0;
      rxByteValid <= 1'b0;
      frameError  <= 1'b0;
    end
    else
    begin
      rxByteValid <= 1'b0;
      case (state)
        rxIdle:
          if (!syncB)
          begin
            state   <= rxStart;
            baudCnt <= '0;
          end
        rxStart:
          if (baudCnt == halfCnt)
          begin
            baudCnt <= '0;
            bitIdx  <= '0;
            state   <= syncB ? rxIdle : rxData; // Glitch, not a start bit
          end
          else
            baudCnt <= baudCnt + 1'b1;
        rxData:
          if (baudCnt == lastCnt)
          begin
            baudCnt <= '0;
            if (bitIdx == lastBit)
              state <= rxStop;
            else
              bitIdx <= bitIdx + 1'b1;
          end
          else
            baudCnt <= baudCnt + 1'b1;
        rxStop:
          if (baudCnt == lastCnt)
          begin
            if (syncB)
              rxByteValid <= 1'b1;
            else
              frameError <= 1'b1; // Sticky until reset
            state <= rxIdle;
          end
          else
            baudCnt <= baudCnt + 1'b1;
        default: state <= rxIdle;
      endcase
    end
  end

  // LSB arrives first, so shift in from the top
  always_ff @(posedge clk)
  begin
    if (sampleData)
      shiftReg <= {syncB, shiftReg[dataBits-1:1]};
  end

  assign rxByte = shiftReg;

endmodule

`default_nettype wire

/* rtl/uartTx.sv */
`default_nettype none

module uartTx #(
  parameter int clksPerBit = 16
) (
  input  wire           clk,
  input  wire           reset,
  input  wire           txByteValid,
  input  uartPkg::byteT txByte,
  output logic          txByteReady,
  output logic          serialOut
);
  import uartPkg::*;

  localparam int cntW = $clog2(clksPerBit);
  localparam int bitW = $clog2(dataBits);
  localparam logic [cntW-1:0] lastCnt = cntW'(clksPerBit - 1);
  localparam logic [bitW-1:0] lastBit = bitW'(dataBits - 1);

  txStateT         state;
  logic [cntW-1:0] baudCnt;
  logic [bitW-1:0] bitIdx;
  byteT            shiftReg;
  logic            accept;
  logic            bitEnd;
  logic            loadBit;

  assign txByteReady = (state == txIdle);
  assign accept      = txByteValid && txByteReady;
  assign bitEnd      = (baudCnt == lastCnt);
  // Next data bit goes out at the end of start or of a non-final data bit
  assign loadBit     = bitEnd && ((state == txStart) ||
                                  (state == txData && bitIdx != lastBit));

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      state     <= txIdle;
      baudCnt   <= '0;
      bitIdx    <= '0;
      serialOut <= 1'b1;
    end
    else
    begin
      baudCnt <= (state == txIdle || bitEnd) ? '0 : baudCnt + 1'b1;
      if (loadBit)
        serialOut <= shiftReg[0];
      case (state)
        txIdle:
          if (accept)
          begin
            state     <= txStart;
            serialOut <= 1'b0; // Start bit
          end
        txStart:
          if (bitEnd)
          begin
            state  <= txData;
            bitIdx <= '0;
          end
        txData:
          if (bitEnd)
          begin
            if (bitIdx == lastBit)
            begin
              state     <= txStop;
              serialOut <= 1'b1;
            end
            else
              bitIdx <= bitIdx + 1'b1;
          end
        txStop:
          if (bitEnd)
            state <= txIdle;
        default: state <= txIdle;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
      shiftReg <= txByte;
    else if (loadBit)
      shiftReg <= shiftReg >> 1;
  end

endmodule

`default_nettype wire

/* test/uartBridgeTb.sv */
`default_nettype none

module uartBridgeTb;
  timeunit 1ns;
  timeprecision 100ps;
  import uartPkg::*;

  localparam int clksPerBit     = 8;
  localparam int queueDepthLog2 = 2;
  localparam int frameCycles    = 10 * clksPerBit;
  localparam int loopCount      = 20;
  localparam int burstCount     = 12;
  localparam int overrunCount   = 6;
  localparam int injectCount    = 2;
  localparam int totalFrames    = loopCount + burstCount + overrunCount + injectCount;
  // Twice the line time of every frame, plus slack for reset and drain
  localparam longint timeLimitNs = longint'(totalFrames) * frameCycles * 20 * 2 + 20000;

  logic clk = 1'b0;
  logic reset;
  byteT txData;
  logic txValid;
  logic txReady;
  byteT rxData;
  logic rxValid;
  logic rxReady;
  logic serialIn;
  logic serialOut;
  logic rxOverrun;
  logic rxFrameError;
  logic loopMode;  // 1 feeds serialOut back, 0 uses injLine
  logic injLine;
  logic stallSeen;
  logic lineBusy;
  int   lineCnt;
  int   framesSeen;
  int   seed = 32'hc6b0;
  int   errors = 0;
  int   testErrStart = 0;
  int   passedTests = 0;
  int   failedTests = 0;
  byteT expQ[$];   // Bytes still owed by the rx side

  always #10 clk = ~clk;

  assign serialIn = loopMode ? serialOut : injLine;

  uartBridge #(.clksPerBit(clksPerBit), .queueDepthLog2(queueDepthLog2)) dut0 (
    .clk          (clk),
    .reset        (reset),
    .txData       (txData),
    .txValid      (txValid),
    .txReady      (txReady),
    .rxData       (rxData),
    .rxValid      (rxValid),
    .rxReady      (rxReady),
    .serialIn     (serialIn),
    .serialOut    (serialOut),
    .rxOverrun    (rxOverrun),
    .rxFrameError (rxFrameError)
  );

  function automatic int errorTotal();
    return errors + dut0.chk0.failCount;
  endfunction

  task automatic expectTrue(input logic cond, input string msg);
    assert (cond === 1'b1)
    else
    begin
      errors++;
      $display("** Error at %0t ns: %s", $time, msg);
    end
  endtask

  task automatic nextEdge();
    @(posedge clk);
    #2;
  endtask

  // Holds txValid until the byte is taken, txValid stays high afterwards
  task automatic pushByte(input byteT b);
    logic taken;
    int   waits;
    waits   = 0;
    txValid = 1'b1;
    txData  = b;
    do
    begin
      @(posedge clk);
      taken = txReady;
      if (!taken)
        waits++;
      #2;
    end
    while (!taken);
    if (waits > clksPerBit)
      stallSeen = 1'b1; // Only a full queue stalls longer than one bit time
  endtask

  // Hand-built frame, LSB first
  task automatic sendFrame(input byteT b, input logic stopBit);
    logic [9:0] frame;
    frame = {stopBit, b, 1'b0};
    for (int i = 0; i < 10; i++)
    begin
      injLine = frame[i];
      repeat (clksPerBit) nextEdge();
    end
    injLine = 1'b1;
  endtask

  task automatic waitDrain();
    while (expQ.size() != 0)
      nextEdge();
  endtask

  task automatic finishTest(input string name);
    int newErrors;
    newErrors = errorTotal() - testErrStart;
    if (newErrors == 0)
    begin
      passedTests++;
      $display("Test %s: ok", name);
    end
    else
    begin
      failedTests++;
      $display("Test %s: failed with %0d errors", name, newErrors);
    end
    testErrStart = errorTotal();
  endtask

  // Scoreboard, a pop happens on an edge where rxValid and rxReady are high
  always @(posedge clk)
  begin
    if (!reset && rxValid && rxReady)
    begin
      assert (expQ.size() != 0)
      else
      begin
        errors++;
        $display("** Error at %0t ns: byte %02h popped with none expected", $time, rxData);
      end
      if (expQ.size() != 0)
      begin
        assert (rxData == expQ[0])
        else
        begin
          errors++;
          $display("** Error at %0t ns: rxData %02h, expected %02h", $time, rxData, expQ[0]);
        end
        void'(expQ.pop_front());
      end
    end
  end

  // Counts whole frames on serialOut
  always @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      lineBusy   <= 1'b0;
      lineCnt    <= 0;
      framesSeen <= 0;
    end
    else if (!lineBusy)
    begin
      if (!serialOut)
      begin
        lineBusy <= 1'b1;
        lineCnt  <= 1;
      end
    end
    else if (lineCnt == frameCycles - 1)
    begin
      lineBusy   <= 1'b0;
      framesSeen <= framesSeen + 1;
    end
    else
      lineCnt <= lineCnt + 1;
  end

  initial
  begin
    byteT b;
    int   base;
    int   gap;
    reset     = 1'b1;
    txValid   = 1'b0;
    txData    = '0;
    rxReady   = 1'b0;
    loopMode  = 1'b1;
    injLine   = 1'b1;
    stallSeen = 1'b0;
    repeat (10) @(posedge clk);
    #2;
    expectTrue(txReady == 1'b0, "txReady high during reset");
    reset = 1'b0;
    expectTrue(serialOut == 1'b1, "serialOut not high after reset");
    expectTrue(rxValid == 1'b0, "rxValid high after reset");
    expectTrue(rxOverrun == 1'b0, "rxOverrun high after reset");
    expectTrue(rxFrameError == 1'b0, "rxFrameError high after reset");
    repeat (2) nextEdge();
    expectTrue(txReady == 1'b1, "txReady still low 2 cycles after reset");
    finishTest("reset state");

    rxReady = 1'b1;
    for (int i = 0; i < loopCount; i++)
    begin
      b = byteT'($random(seed));
      expQ.push_back(b);
      pushByte(b);
      txValid = 1'b0;
      gap = {$random(seed)} % 4;
      repeat (gap) nextEdge();
    end
    waitDrain();
    finishTest("loopback order");

    stallSeen = 1'b0;
    for (int i = 0; i < burstCount; i++)
    begin
      b = byteT'($random(seed));
      expQ.push_back(b);
      pushByte(b);
    end
    txValid = 1'b0;
    waitDrain();
    expectTrue(stallSeen, "txReady never held low by a full tx queue during a burst");
    finishTest("tx back-pressure");

    rxReady = 1'b0;
    base    = framesSeen;
    for (int i = 0; i < overrunCount; i++)
    begin
      b = byteT'($random(seed));
      if (i < 2 ** queueDepthLog2)
        expQ.push_back(b); // Later bytes find the rx queue full
      pushByte(b);
    end
    txValid = 1'b0;
    while (framesSeen < base + overrunCount)
      nextEdge();
    repeat (clksPerBit / 2) nextEdge(); // Last byte lands mid stop bit
    expectTrue(rxOverrun == 1'b1, "rxOverrun not set after overfilling the rx queue");
    rxReady = 1'b1;
    waitDrain();
    finishTest("rx overrun");

    loopMode = 1'b0;
    nextEdge();
    sendFrame(byteT'($random(seed)), 1'b0);
    repeat (clksPerBit) nextEdge();
    expectTrue(rxFrameError == 1'b1, "rxFrameError not set by a low stop bit");
    expectTrue(rxValid == 1'b0, "frame with a low stop bit produced a byte");
    b = byteT'($random(seed));
    expQ.push_back(b);
    sendFrame(b, 1'b1);
    waitDrain();
    finishTest("framing error");

    $display("Tests: %0d passed, %0d failed, %0d errors in total",
             passedTests, failedTests, errorTotal());
    if (errorTotal() == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

  initial
  begin
    #(timeLimitNs);
    $display("Watchdog expired at %0t ns, a test did not finish in time", $time);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

`default_nettype wire

/* test/uartBridge_chk.sv */
`default_nettype none

module uartBridgeChk (
  input wire              clk,
  input wire              reset,
  input uartPkg::txStateT txState,
  input wire              serialOut,
  input uartPkg::byteT    rxData,
  input wire              rxValid,
  input wire              rxReady,
  input wire              rxOverrun,
  input wire              grantA,
  input wire              grantB
);
  timeunit 1ns;
  timeprecision 100ps;
  import uartPkg::*;

  int failCount = 0; // Read by the testbench at the end

  // Line idles high between frames
  idleLineHigh: assert property (@(posedge clk) disable iff (reset)
    (txState == txIdle) |-> serialOut)
  else
  begin
    failCount++;
    $error("serialOut low while the transmitter is idle");
  end

  rxDataHeld: assert property (@(posedge clk) disable iff (reset)
    (rxValid && !rxReady) |=> $stable(rxData))
  else
  begin
    failCount++;
    $error("rxData changed while waiting for rxReady");
  end

  overrunSticky: assert property (@(posedge clk) disable iff (reset)
    !$fell(rxOverrun))
  else
  begin
    failCount++;
    $error("rxOverrun cleared without reset");
  end

  // Single port RAM serves one queue per cycle
  oneGrant: assert property (@(posedge clk) disable iff (reset)
    !(grantA && grantB))
  else
  begin
    failCount++;
    $error("both RAM ports granted in one cycle");
  end

endmodule

bind uartBridge uartBridgeChk chk0 (
  .clk       (clk),
  .reset     (reset),
  .txState   (tx0.state),
  .serialOut (serialOut),
  .rxData    (rxData),
  .rxValid   (rxValid),
  .rxReady   (rxReady),
  .rxOverrun (rxOverrun),
  .grantA    (txMem.reqReady),
  .grantB    (rxMem.reqReady)
);

`default_nettype wire
